// ==== common/flow_pkg.sv ====
/* Shared widths, descriptor field positions and enums for the active-mode command flow.
   Imported by every RTL block of the flow. */
package flow_pkg;

  // Bus and table widths
  localparam int unsigned CmdWidth    = 64;
  localparam int unsigned RespWidth   = 32;
  localparam int unsigned DatWidth    = 64;
  localparam int unsigned DatIdxWidth = 5;
  localparam int unsigned CntWidth    = 3;

  // Command descriptor fields
  localparam int unsigned CmdAttrLsb   = 0;
  localparam int unsigned CmdTidLsb    = 3;
  localparam int unsigned CmdDevIdxLsb = 16;
  localparam int unsigned CmdDttLsb    = 23;
  localparam int unsigned CmdRnwBit    = 29;
  localparam int unsigned CmdTocBit    = 31;
  localparam int unsigned CmdByte1Lsb  = 32;

  // DAT entry fields
  localparam int unsigned DatAddrLsb   = 0;
  localparam int unsigned DatLegacyBit = 31;

  // Response descriptor fields, data length sits at the bottom
  localparam int unsigned RespErrLsb = 28;
  localparam int unsigned RespTidLsb = 24;

  // DTT values from here up carry a defining byte in byte 1
  localparam int unsigned DefByteDtt      = 5;
  localparam int unsigned BytesBeforeData = 1;

  typedef enum logic [2:0] {
    RegularTransfer       = 3'd0,
    ImmediateDataTransfer = 3'd1,
    AddressAssignment     = 3'd2,
    ComboTransfer         = 3'd3,
    InternalControl       = 3'd7
  } cmd_attr_e;

  typedef enum logic [3:0] {
    Success      = 4'h0,
    NotSupported = 4'hA
  } resp_err_e;

  typedef enum logic [2:0] {
    Idle,
    WaitForCmd,
    FetchDat,
    I2cWriteImm,
    WriteResp
  } flow_state_e;

endpackage

// ==== flow/flow_active.sv ====
/* Top of the active command flow between the HCI queues, the DAT and the I2C controller.
   Connects decoder, DAT reader, write sequencer and flow controller. */
module flow_active (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  logic                             cmd_valid_i,
  input  logic [flow_pkg::CmdWidth-1:0]    cmd_data_i,
  input  logic [flow_pkg::DatWidth-1:0]    dat_rdata_i,
  input  logic                             fmt_ready_i,
  input  logic                             resp_ready_i,
  output logic                             idle_o,
  output logic                             cmd_ready_o,
  output logic                             dat_read_o,
  output logic [flow_pkg::DatIdxWidth-1:0] dat_index_o,
  output logic                             fmt_valid_o,
  output logic [7:0]                       fmt_byte_o,
  output logic                             fmt_start_o,
  output logic                             fmt_stop_o,
  output logic                             resp_valid_o,
  output logic [flow_pkg::RespWidth-1:0]   resp_data_o
);
  import flow_pkg::*;

  // Decoded command fields
  logic [3:0]             cmd_tid;
  cmd_attr_e              cmd_attr;
  logic                   cmd_rnw;
  logic [DatIdxWidth-1:0] dev_index;
  logic                   cmd_toc;
  logic [CntWidth-1:0]    cmd_data_len;
  logic [3:0][7:0]        cmd_payload;

  logic       cmd_load;
  logic       dat_start;
  logic       dat_done;
  logic [6:0] static_addr;
  logic       legacy;
  logic       seq_start;
  logic       seq_done;

  cmd_decoder u_cmd_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .load_i      (cmd_load),
    .cmd_data_i  (cmd_data_i),
    .tid_o       (cmd_tid),
    .attr_o      (cmd_attr),
    .rnw_o       (cmd_rnw),
    .dev_index_o (dev_index),
    .toc_o       (cmd_toc),
    // Defining byte is already folded into length and payload
    .def_byte_o  (),
    .data_len_o  (cmd_data_len),
    .payload_o   (cmd_payload)
  );

  dat_reader u_dat_reader (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (dat_start),
    .index_i       (dev_index),
    .dat_rdata_i   (dat_rdata_i),
    .dat_read_o    (dat_read_o),
    .dat_index_o   (dat_index_o),
    .done_o        (dat_done),
    .static_addr_o (static_addr),
    .legacy_o      (legacy)
  );

  imm_write_seq u_imm_write_seq (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (seq_start),
    .static_addr_i (static_addr),
    .payload_i     (cmd_payload),
    .data_len_i    (cmd_data_len),
    .toc_i         (cmd_toc),
    .fmt_ready_i   (fmt_ready_i),
    .fmt_valid_o   (fmt_valid_o),
    .fmt_byte_o    (fmt_byte_o),
    .fmt_start_o   (fmt_start_o),
    .fmt_stop_o    (fmt_stop_o),
    .done_o        (seq_done)
  );

  flow_ctrl u_flow_ctrl (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .en_i         (en_i),
    .cmd_valid_i  (cmd_valid_i),
    .attr_i       (cmd_attr),
    .rnw_i        (cmd_rnw),
    .tid_i        (cmd_tid),
    .data_len_i   (cmd_data_len),
    .dat_done_i   (dat_done),
    .legacy_i     (legacy),
    .seq_done_i   (seq_done),
    .resp_ready_i (resp_ready_i),
    .idle_o       (idle_o),
    .cmd_ready_o  (cmd_ready_o),
    .cmd_load_o   (cmd_load),
    .dat_start_o  (dat_start),
    .seq_start_o  (seq_start),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o)
  );

endmodule

// ==== flow/flow_ctrl.sv ====
/* State machine of the active command flow and builder of the response descriptor.
   Sequences command fetch, DAT lookup, the I2C write and the response write. */
module flow_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic                           cmd_valid_i,
  input  flow_pkg::cmd_attr_e            attr_i,
  input  logic                           rnw_i,
  input  logic [3:0]                     tid_i,
  input  logic [flow_pkg::CntWidth-1:0]  data_len_i,
  input  logic                           dat_done_i,
  input  logic                           legacy_i,
  input  logic                           seq_done_i,
  input  logic                           resp_ready_i,
  output logic                           idle_o,
  output logic                           cmd_ready_o,
  output logic                           cmd_load_o,
  output logic                           dat_start_o,
  output logic                           seq_start_o,
  output logic                           resp_valid_o,
  output logic [flow_pkg::RespWidth-1:0] resp_data_o
);
  import flow_pkg::*;

  flow_state_e         state_q, state_d;
  resp_err_e           err_q;
  logic [CntWidth-1:0] len_q;
  logic                i2c_write;
  logic                dat_ready;

  // Only legacy immediate writes are carried out
  assign i2c_write = (attr_i == ImmediateDataTransfer) & ~rnw_i & legacy_i;
  assign dat_ready = (state_q == FetchDat) & dat_done_i;

  assign idle_o       = (state_q == Idle);
  assign cmd_ready_o  = (state_q == WaitForCmd);
  assign cmd_load_o   = cmd_ready_o & cmd_valid_i;
  // DAT lookup is kicked off by the command handshake itself
  assign dat_start_o  = cmd_load_o;
  assign seq_start_o  = dat_ready & i2c_write;
  assign resp_valid_o = (state_q == WriteResp);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle:        if (en_i) state_d = WaitForCmd;
      WaitForCmd:  if (cmd_valid_i) state_d = FetchDat;
      FetchDat:    if (dat_done_i) state_d = i2c_write ? I2cWriteImm : WriteResp;
      I2cWriteImm: if (seq_done_i) state_d = WriteResp;
      WriteResp:   if (resp_ready_i) state_d = Idle;
      default:     state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      err_q   <= Success;
      len_q   <= '0;
    end else begin
      state_q <= state_d;
      // Outcome is fixed once the DAT entry is known
      if (dat_ready) begin
        err_q <= i2c_write ? Success : NotSupported;
        len_q <= i2c_write ? data_len_i : '0;
      end
    end
  end

  always_comb begin
    resp_data_o                      = '0;
    resp_data_o[RespErrLsb +: 4]     = err_q;
    resp_data_o[RespTidLsb +: 4]     = tid_i;
    resp_data_o[15:0]                = 16'(len_q);
  end

endmodule

// ==== flow/imm_write_seq.sv ====
/* Feeds the I2C controller format FIFO for an immediate write to a legacy device.
   Sends the address byte with start, then the payload, and flags stop on the last item. */
module imm_write_seq (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          start_i,
  input  logic [6:0]                    static_addr_i,
  input  logic [3:0][7:0]               payload_i,
  input  logic [flow_pkg::CntWidth-1:0] data_len_i,
  input  logic                          toc_i,
  input  logic                          fmt_ready_i,
  output logic                          fmt_valid_o,
  output logic [7:0]                    fmt_byte_o,
  output logic                          fmt_start_o,
  output logic                          fmt_stop_o,
  output logic                          done_o
);
  import flow_pkg::*;

  logic                active_q;
  logic                done_q;
  logic [CntWidth-1:0] cnt_q;
  logic [CntWidth-1:0] last_idx;
  logic [1:0]          byte_sel;
  logic                is_last;
  logic                fmt_hs;

  // Address item comes first, so the last item index equals the data length
  assign last_idx = data_len_i + CntWidth'(BytesBeforeData - 1);
  assign is_last  = (cnt_q == last_idx);
  assign fmt_hs   = active_q & fmt_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= fmt_hs & is_last;
      if (start_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (fmt_hs) begin
        if (is_last) begin
          active_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q + CntWidth'(1);
        end
      end
    end
  end

  // Item 1 maps to payload byte 0
  assign byte_sel = 2'(cnt_q - CntWidth'(BytesBeforeData));

  always_comb begin
    if (cnt_q == '0) begin
      // Target address, write direction
      fmt_byte_o = {static_addr_i, 1'b0};
    end else begin
      fmt_byte_o = payload_i[byte_sel];
    end
  end

  assign fmt_valid_o = active_q;
  assign fmt_start_o = active_q & (cnt_q == '0);
  assign fmt_stop_o  = active_q & is_last & toc_i;
  assign done_o      = done_q;

endmodule

// ==== flow_active.f ====
common/flow_pkg.sv
src/cmd_decoder.sv
src/dat_reader.sv
flow/imm_write_seq.sv
flow/flow_ctrl.sv
flow/flow_active.sv
testbench/flow_active_chk.sv
testbench/flow_scoreboard.sv
testbench/tb_flow_active.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the flow testbench with Verilator, run it and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_flow_active -f flow_active.f -o sim_flow_active \
  && ./obj_dir/sim_flow_active +verilator+error+limit+1000 > sim.log 2>&1 \
  || { echo "Simulation build or run failed"; exit 1; }
grep -q "TEST RESULT: FAIL" sim.log \
  && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation passed, see sim.log"
exit 0

// ==== src/cmd_decoder.sv ====
/* Holds the command descriptor taken from the command queue and decodes its fields.
   Loaded once per command on the queue handshake. */
module cmd_decoder (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               load_i,
  input  logic [flow_pkg::CmdWidth-1:0]      cmd_data_i,
  output logic [3:0]                         tid_o,
  output flow_pkg::cmd_attr_e                attr_o,
  output logic                               rnw_o,
  output logic [flow_pkg::DatIdxWidth-1:0]   dev_index_o,
  output logic                               toc_o,
  output logic                               def_byte_o,
  output logic [flow_pkg::CntWidth-1:0]      data_len_o,
  output logic [3:0][7:0]                    payload_o
);
  import flow_pkg::*;

  logic [CmdWidth-1:0] desc_q;
  logic [2:0]          dtt;
  logic [3:0][7:0]     data_bytes;
  logic                is_imm;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      desc_q <= '0;
    end else if (load_i) begin
      desc_q <= cmd_data_i;
    end
  end

  assign tid_o       = desc_q[CmdTidLsb +: 4];
  assign attr_o      = cmd_attr_e'(desc_q[CmdAttrLsb +: 3]);
  assign rnw_o       = desc_q[CmdRnwBit];
  assign dev_index_o = desc_q[CmdDevIdxLsb +: DatIdxWidth];
  assign toc_o       = desc_q[CmdTocBit];
  assign dtt         = desc_q[CmdDttLsb +: 3];
  assign is_imm      = (attr_o == ImmediateDataTransfer);

  // Payload octets in the upper word, byte 1 lowest
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      data_bytes[i] = desc_q[CmdByte1Lsb + 8 * i +: 8];
    end
  end

  assign def_byte_o = is_imm && (dtt >= DefByteDtt);

  always_comb begin
    if (!is_imm) begin
      data_len_o = '0;
    end else if (def_byte_o) begin
      data_len_o = CntWidth'(dtt - DefByteDtt);
    end else begin
      data_len_o = CntWidth'(dtt);
    end
  end

  // Defining byte is not payload, data starts at byte 2
  assign payload_o = def_byte_o ? {8'h00, data_bytes[3], data_bytes[2], data_bytes[1]}
                                : data_bytes;

endmodule

// ==== src/dat_reader.sv ====
/* Reads one device address table entry per command and keeps its address and type.
   The table answers one cycle after the read strobe. */
module dat_reader (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             start_i,
  input  logic [flow_pkg::DatIdxWidth-1:0] index_i,
  input  logic [flow_pkg::DatWidth-1:0]    dat_rdata_i,
  output logic                             dat_read_o,
  output logic [flow_pkg::DatIdxWidth-1:0] dat_index_o,
  output logic                             done_o,
  output logic [6:0]                       static_addr_o,
  output logic                             legacy_o
);
  import flow_pkg::*;

  logic read_q;
  logic capture_q;
  logic done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_q    <= 1'b0;
      capture_q <= 1'b0;
      done_q    <= 1'b0;
    end else begin
      // Single strobe even if start is held
      read_q    <= start_i & ~read_q;
      capture_q <= read_q;
      done_q    <= capture_q;
    end
  end

  // Entry fields, held until the next read
  always_ff @(posedge clk_i) begin
    if (capture_q) begin
      static_addr_o <= dat_rdata_i[DatAddrLsb +: 7];
      legacy_o      <= dat_rdata_i[DatLegacyBit];
    end
  end

  assign dat_read_o  = read_q;
  assign dat_index_o = read_q ? index_i : '0;
  assign done_o      = done_q;

endmodule

// ==== testbench/flow_active_chk.sv ====
/* Handshake assertions for the active command flow.
   Bound into flow_active by the testbench top. */
module flow_active_chk (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           idle_o,
  input logic                           cmd_ready_o,
  input logic                           dat_read_o,
  input logic                           fmt_valid_o,
  input logic                           fmt_ready_i,
  input logic [7:0]                     fmt_byte_o,
  input logic                           fmt_start_o,
  input logic                           fmt_stop_o,
  input logic                           resp_valid_o,
  input logic                           resp_ready_i,
  input logic [flow_pkg::RespWidth-1:0] resp_data_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // Stalled format item keeps its value
  fmt_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fmt_valid_o && !fmt_ready_i |=> fmt_valid_o && $stable(fmt_byte_o)
      && $stable(fmt_start_o) && $stable(fmt_stop_o))
    else begin
      fail_count++;
      $error("format item changed while the FIFO was stalled");
    end

  resp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_data_o))
    else begin
      fail_count++;
      $error("response changed while the queue was stalled");
    end

  ready_idle_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(cmd_ready_o && idle_o))
    else begin
      fail_count++;
      $error("command ready raised while idle");
    end

  // DAT strobe is a single pulse
  dat_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dat_read_o |=> !dat_read_o)
    else begin
      fail_count++;
      $error("DAT read strobe longer than one cycle");
    end

endmodule

// ==== testbench/flow_scoreboard.sv ====
/* Watches the flow DUT, predicts the format items and response of each command
   and compares them with what the DUT sends. */
module flow_scoreboard (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  logic                             idle_i,
  input  logic                             cmd_valid_i,
  input  logic                             cmd_ready_i,
  input  logic [flow_pkg::CmdWidth-1:0]    cmd_data_i,
  input  logic                             dat_read_i,
  input  logic [flow_pkg::DatIdxWidth-1:0] dat_index_i,
  input  logic [flow_pkg::DatWidth-1:0]    dat_rdata_i,
  input  logic                             fmt_valid_i,
  input  logic                             fmt_ready_i,
  input  logic [7:0]                       fmt_byte_i,
  input  logic                             fmt_start_i,
  input  logic                             fmt_stop_i,
  input  logic                             resp_valid_i,
  input  logic                             resp_ready_i,
  input  logic [flow_pkg::RespWidth-1:0]   resp_data_i,
  output int                               errors_o,
  output int                               resp_count_o,
  output int                               pending_o
);
  timeunit 1ns;
  timeprecision 1ps;
  import flow_pkg::*;

  logic [63:0] cur_desc;
  logic [9:0]  exp_q[$];
  logic [31:0] exp_resp;
  logic        resp_pending;
  logic        read_due;
  logic        read_seen;
  logic        idle_hold;

  // Items are {start, stop, byte}; only legacy immediate writes produce any
  function automatic void predict(input logic [63:0] desc, input logic [63:0] entry,
                                  output int n_items, output logic [4:0][9:0] items,
                                  output logic [31:0] resp);
    logic [2:0] dtt;
    logic       toc;
    int         first;
    int         len;
    dtt = desc[25:23];
    toc = desc[31];
    items = '0;
    n_items = 0;
    resp = '0;
    resp[27:24] = desc[6:3];
    if (desc[2:0] == 3'(ImmediateDataTransfer) && !desc[29] && entry[31]) begin
      // Byte 1 is the defining byte from DTT 5 up
      first = (dtt >= 3'd5) ? 1 : 0;
      len = (dtt >= 3'd5) ? int'(dtt) - 5 : int'(dtt);
      items[0] = {1'b1, toc && (len == 0), entry[6:0], 1'b0};
      for (int k = 1; k <= len; k++) begin
        items[k] = {1'b0, toc && (k == len), desc[32 + 8 * (first + k - 1) +: 8]};
      end
      n_items = len + 1;
      resp[31:28] = Success;
      resp[15:0] = 16'(len);
    end else begin
      resp[31:28] = NotSupported;
    end
  endfunction

  task automatic note_error(input string what);
    $display("Scoreboard error: %s at %0t", what, $time);
    errors_o++;
  endtask

  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    if (got !== want) begin
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
      errors_o++;
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin : watch
    int              n_items;
    logic [4:0][9:0] items;
    logic [9:0]      want;
    if (!rst_ni) begin
      exp_q.delete();
      resp_pending = 1'b0;
      read_due = 1'b0;
      read_seen = 1'b0;
      idle_hold = 1'b0;
      errors_o = 0;
      resp_count_o = 0;
    end else begin
      if (idle_hold && !idle_i) begin
        note_error("flow left idle while en_i was low");
      end
      idle_hold = idle_i && !en_i;
      // DAT read due one cycle after the command handshake
      if (read_due) begin
        if (!dat_read_i) begin
          note_error("no DAT read one cycle after the command handshake");
        end else begin
          compare_field("dat_index_o", 32'(dat_index_i), 32'(cur_desc[20:16]));
        end
      end else if (dat_read_i) begin
        note_error("DAT read without a command");
      end
      read_due = 1'b0;
      if (cmd_valid_i && cmd_ready_i) begin
        cur_desc = cmd_data_i;
        read_due = 1'b1;
      end
      if (read_seen) begin
        predict(cur_desc, dat_rdata_i, n_items, items, exp_resp);
        for (int i = 0; i < n_items; i++) begin
          exp_q.push_back(items[i]);
        end
        resp_pending = 1'b1;
      end
      read_seen = dat_read_i;
      if (fmt_valid_i && fmt_ready_i) begin
        if (exp_q.size() == 0) begin
          note_error("format item sent with none expected");
        end else begin
          want = exp_q.pop_front();
          compare_field("fmt_byte_o", 32'(fmt_byte_i), 32'(want[7:0]));
          compare_field("fmt_start_o", 32'(fmt_start_i), 32'(want[9]));
          compare_field("fmt_stop_o", 32'(fmt_stop_i), 32'(want[8]));
        end
      end
      if (resp_valid_i && resp_ready_i) begin
        resp_count_o++;
        if (!resp_pending) begin
          note_error("response sent with none expected");
        end else begin
          if (exp_q.size() != 0) begin
            note_error("response sent before all format items");
          end
          compare_field("resp_data_o", resp_data_i, exp_resp);
          resp_pending = 1'b0;
        end
      end
    end
    pending_o = exp_q.size() + (resp_pending ? 1 : 0);
  end

endmodule

// ==== testbench/tb_flow_active.sv ====
/* Testbench for the active command flow, with a DAT model, random FIFO back-pressure
   and directed plus random commands. */
module tb_flow_active;
  timeunit 1ns;
  timeprecision 1ps;
  import flow_pkg::*;

  localparam int WaitLimit = 200;

  logic             clk_i;
  logic             rst_ni;
  logic             en_i;
  logic             cmd_valid_i;
  logic [63:0]      cmd_data_i;
  logic [63:0]      dat_rdata_i;
  logic             fmt_ready_i;
  logic             resp_ready_i;
  logic             idle_o;
  logic             cmd_ready_o;
  logic             dat_read_o;
  logic [4:0]       dat_index_o;
  logic             fmt_valid_o;
  logic [7:0]       fmt_byte_o;
  logic             fmt_start_o;
  logic             fmt_stop_o;
  logic             resp_valid_o;
  logic [31:0]      resp_data_o;

  integer      seed = 32'ha79880c9;
  logic [63:0] dat_mem[32];
  logic        read_pending;
  logic [4:0]  pending_idx;
  logic        timed_out;
  int          tb_errors;
  int          cmd_count;
  int          sb_errors;
  int          resp_count;
  int          pending;

  flow_active UUT (.*);

  bind flow_active flow_active_chk u_chk (
    .clk_i(clk_i), .rst_ni(rst_ni), .idle_o(idle_o), .cmd_ready_o(cmd_ready_o),
    .dat_read_o(dat_read_o), .fmt_valid_o(fmt_valid_o), .fmt_ready_i(fmt_ready_i),
    .fmt_byte_o(fmt_byte_o), .fmt_start_o(fmt_start_o), .fmt_stop_o(fmt_stop_o),
    .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i), .resp_data_o(resp_data_o)
  );

  flow_scoreboard u_scoreboard (
    .clk_i(clk_i), .rst_ni(rst_ni), .en_i(en_i), .idle_i(idle_o),
    .cmd_valid_i(cmd_valid_i), .cmd_ready_i(cmd_ready_o), .cmd_data_i(cmd_data_i),
    .dat_read_i(dat_read_o), .dat_index_i(dat_index_o), .dat_rdata_i(dat_rdata_i),
    .fmt_valid_i(fmt_valid_o), .fmt_ready_i(fmt_ready_i), .fmt_byte_i(fmt_byte_o),
    .fmt_start_i(fmt_start_o), .fmt_stop_i(fmt_stop_o), .resp_valid_i(resp_valid_o),
    .resp_ready_i(resp_ready_i), .resp_data_i(resp_data_o), .errors_o(sb_errors),
    .resp_count_o(resp_count), .pending_o(pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // Random back-pressure and a DAT that answers one cycle after the strobe
  always @(negedge clk_i) begin
    fmt_ready_i  = 1'($random(seed));
    resp_ready_i = 1'($random(seed));
    if (read_pending) begin
      dat_rdata_i = dat_mem[pending_idx];
    end else begin
      dat_rdata_i = {$random(seed), $random(seed)};
    end
    read_pending = dat_read_o;
    pending_idx  = dat_index_o;
  end

  function automatic logic [63:0] make_cmd(input logic [2:0] attr, input logic [3:0] tid,
                                           input logic [4:0] idx, input logic [2:0] dtt,
                                           input logic rnw, input logic toc,
                                           input logic [31:0] data);
    logic [63:0] desc;
    desc = '0;
    desc[2:0]   = attr;
    desc[6:3]   = tid;
    desc[20:16] = idx;
    desc[25:23] = dtt;
    desc[29]    = rnw;
    desc[31]    = toc;
    desc[63:32] = data;
    return desc;
  endfunction

  // Offer one command, then wait until the flow is back in idle
  task automatic run_cmd(input logic [63:0] desc);
    int cycles;
    if (timed_out) return;
    @(negedge clk_i);
    cmd_valid_i = 1'b1;
    cmd_data_i  = desc;
    cycles = 0;
    while (!cmd_ready_o && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!cmd_ready_o) begin
      $display("Timeout: the command queue was never accepted");
      timed_out = 1'b1;
      tb_errors++;
      cmd_valid_i = 1'b0;
      return;
    end
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    cmd_data_i  = {$random(seed), $random(seed)};
    cmd_count++;
    cycles = 0;
    while (!idle_o && cycles < WaitLimit) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!idle_o) begin
      $display("Timeout: the flow did not return to idle after a command");
      timed_out = 1'b1;
      tb_errors++;
    end
  endtask

  initial begin
    logic [63:0] entry;
    logic [31:0] rnd;
    int          chk_fails;
    int          total;
    rst_ni = 1'b0;
    en_i = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_data_i = '0;
    dat_rdata_i = '0;
    fmt_ready_i = 1'b0;
    resp_ready_i = 1'b0;
    read_pending = 1'b0;
    pending_idx = '0;
    timed_out = 1'b0;
    tb_errors = 0;
    cmd_count = 0;
    // Static address tracks the index, legacy flag is random
    for (int i = 0; i < 32; i++) begin
      entry = {$random(seed), $random(seed)};
      entry[6:0] = {2'b10, 5'(i)};
      dat_mem[i] = entry;
    end
    dat_mem[3][31] = 1'b1;
    dat_mem[4][31] = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Disabled flow must ignore a waiting command
    cmd_valid_i = 1'b1;
    cmd_data_i = make_cmd(3'(ImmediateDataTransfer), 4'h1, 5'd3, 3'd2, 1'b0, 1'b1, 32'h0);
    repeat (10) begin
      @(negedge clk_i);
      if (!idle_o || cmd_ready_o) begin
        $display("Flow left idle or took a command while en_i was low");
        tb_errors++;
      end
    end
    cmd_valid_i = 1'b0;
    en_i = 1'b1;

    for (int dtt = 0; dtt < 8; dtt++) begin
      for (int toc = 0; toc < 2; toc++) begin
        run_cmd(make_cmd(3'(ImmediateDataTransfer), 4'(dtt), 5'd3, 3'(dtt), 1'b0, 1'(toc),
                         $random(seed)));
      end
    end

    // Unsupported attributes, an immediate read, and a write to an I3C device
    run_cmd(make_cmd(3'(RegularTransfer), 4'hA, 5'd3, 3'd2, 1'b0, 1'b1, $random(seed)));
    run_cmd(make_cmd(3'(ComboTransfer), 4'h2, 5'd3, 3'd4, 1'b0, 1'b1, $random(seed)));
    run_cmd(make_cmd(3'(AddressAssignment), 4'h3, 5'd3, 3'd1, 1'b0, 1'b0, $random(seed)));
    run_cmd(make_cmd(3'(InternalControl), 4'h4, 5'd3, 3'd3, 1'b0, 1'b1, $random(seed)));
    run_cmd(make_cmd(3'd5, 4'h5, 5'd3, 3'd2, 1'b0, 1'b1, $random(seed)));
    run_cmd(make_cmd(3'(ImmediateDataTransfer), 4'hB, 5'd3, 3'd3, 1'b1, 1'b1, $random(seed)));
    run_cmd(make_cmd(3'(ImmediateDataTransfer), 4'hC, 5'd4, 3'd3, 1'b0, 1'b1, $random(seed)));

    for (int n = 0; n < 60; n++) begin
      rnd = $random(seed);
      run_cmd(make_cmd(rnd[1] ? 3'(ImmediateDataTransfer) : rnd[4:2], rnd[8:5], rnd[13:9],
                       rnd[16:14], rnd[17] & rnd[18], rnd[19], $random(seed)));
    end

    if (!timed_out && (pending != 0 || resp_count != cmd_count)) begin
      $display("Responses or format items missing at the end of the run");
      tb_errors++;
    end
    chk_fails = int'(UUT.u_chk.fail_count);
    total = tb_errors + sb_errors + chk_fails;
    $display("Errors: %0d (scoreboard %0d, assertions %0d, testbench %0d), commands %0d",
             total, sb_errors, chk_fails, tb_errors, cmd_count);
    if (!timed_out && total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
